// File: bank_tracker.sv
`timescale 1ns/1ps

module bank_tracker (
  input  logic                     INPUT_CLK,
  input  logic                     RST,
  input  logic                     refresh_strobe,
  input  sdram_sched_pkg::sdr_bus_t sdr,
  output sdram_sched_pkg::page_t    open_page,
  output logic                     page_open,
  output logic                     refresh_pending
);
  import sdram_sched_pkg::*;

  logic strobe_q;
  logic strobe_ack;

  // ----------------------------------------
  // Page state from the issued bus
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      open_page <= '0;
    else if (sdr.cmd == ACTV)
    begin
      open_page.row  <= sdr.addr[ROW_W-1:0];  // Row rides on the address bus
      open_page.bank <= sdr.bank;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      page_open <= 1'b0;
    else
    begin
      case (sdr.cmd)
        ACTV:       page_open <= 1'b1;
        PRCH, ARSR: page_open <= 1'b0;
        default:    ;
      endcase
    end
  end

  // ----------------------------------------
  // Refresh strobe
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      strobe_q   <= refresh_strobe;
      strobe_ack <= refresh_strobe;  // Current level counts as seen
    end
    else
    begin
      strobe_q <= refresh_strobe;
      if (sdr.cmd == ARSR)
        strobe_ack <= strobe_q;  // Also absorbs a second toggle
    end
  end

  assign refresh_pending = strobe_ack ^ strobe_q;

endmodule

// File: command_issuer.sv
`timescale 1ns/1ps

module command_issuer (
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  sdram_sched_pkg::sel_req_t  sel,
  input  logic                      page_hit,
  input  sdram_sched_pkg::page_t     open_page,
  input  logic                      page_open,
  input  logic                      refresh_pending,
  input  logic                      cmd_ready,
  output sdram_sched_pkg::sdr_bus_t  sdr,
  output logic                      rand_grant,
  output logic                      bulk_grant
);
  import sdram_sched_pkg::*;

  sdram_cmd_e            next_cmd;
  logic [BUS_ADDR_W-1:0] next_addr;
  logic [BANK_W-1:0]     next_bank;
  logic                  is_rw;

  // ----------------------------------------
  // Command decision
  // ----------------------------------------
  always_comb
  begin
    next_cmd = NOP;
    if (cmd_ready)
    begin
      if (refresh_pending)
        next_cmd = page_open ? PRCH : ARSR;  // Refresh first
      else if (sel.valid)
      begin
        if (page_hit)
          next_cmd = sel.we ? WRTE : READ;
        else if (page_open)
          next_cmd = PRCH;  // Wrong page
        else
          next_cmd = ACTV;
      end
    end
  end

  assign is_rw = (next_cmd == READ) || (next_cmd == WRTE);

  // ----------------------------------------
  // Address and bank forming
  // ----------------------------------------
  always_comb
  begin
    case (next_cmd)
      ACTV:
      begin
        next_addr = sel.page.row;
        next_bank = sel.page.bank;
      end
      READ, WRTE:
      begin
        next_addr = BUS_ADDR_W'({sel.col, 1'b0});  // 32-bit words on a x16 part
        next_bank = open_page.bank;
      end
      default:
      begin
        next_addr = PRCH_ALL_ADDR;
        next_bank = open_page.bank;
      end
    endcase
  end

  // ----------------------------------------
  // Bus register and grants
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      sdr        <= '{cmd: NOP, bank: '0, addr: '0, dm: '0};
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
    end
    else
    begin
      sdr.cmd    <= next_cmd;
      sdr.bank   <= next_bank;
      sdr.addr   <= next_addr;
      sdr.dm     <= is_rw ? sel.mask : '0;
      rand_grant <= is_rw && !sel.from_bulk;  // Same cycle as READ/WRTE on the bus
      bulk_grant <= is_rw && sel.from_bulk;
    end
  end

endmodule

// File: command_timer.sv
`timescale 1ns/1ps

module command_timer (
  input  logic                     INPUT_CLK,
  input  logic                     RST,
  input  sdram_sched_pkg::sdr_bus_t sdr,
  output logic                     cmd_ready
);
  import sdram_sched_pkg::*;

  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [GAP_CNT_W-1:0] gap_load;

  always_comb
  begin
    case (sdr.cmd)
      ACTV:    gap_load = GAP_ACTV;
      PRCH:    gap_load = GAP_PRCH;
      ARSR:    gap_load = GAP_ARSR;
      WRTE:    gap_load = GAP_WRTE;
      default: gap_load = GAP_READ;
    endcase
  end

  // Loaded one cycle after the command, issue lands one cycle after ready,
  // so two cycles of the gap are already covered
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      gap_cnt <= '0;
    else if (sdr.cmd != NOP)
      gap_cnt <= gap_load - GAP_CNT_W'(2);
    else if (gap_cnt != '0)
      gap_cnt <= gap_cnt - 1'b1;
  end

  assign cmd_ready = (gap_cnt == '0) && (sdr.cmd == NOP);

endmodule

// File: request_select.sv
`timescale 1ns/1ps

module request_select (
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  sdram_sched_pkg::port_req_t rand_port,
  input  sdram_sched_pkg::port_req_t bulk_port,
  input  sdram_sched_pkg::page_t     open_page,
  input  logic                      page_open,
  output sdram_sched_pkg::sel_req_t  sel,
  output logic                      page_hit
);
  import sdram_sched_pkg::*;

  port_req_t rand_q;
  port_req_t bulk_q;
  port_req_t chosen;

  // ----------------------------------------
  // Port sampling
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_q <= '0;
      bulk_q <= '0;
    end
    else
    begin
      rand_q <= rand_port;
      bulk_q <= bulk_port;
    end
  end

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------
  always_comb
  begin
    if (bulk_q.req)
      chosen = bulk_q;  // Bulk wins
    else
      chosen = rand_q;
  end

  always_comb
  begin
    sel.valid     = bulk_q.req | rand_q.req;
    sel.from_bulk = bulk_q.req;
    sel.we        = chosen.we;
    sel.page.row  = chosen.addr.row;
    sel.page.bank = chosen.addr.bank;
    sel.col       = chosen.addr.col;
    sel.mask      = chosen.mask;
  end

  // Compared against the sampled request, not the pins
  assign page_hit = page_open && (sel.page == open_page);

endmodule

// File: sdram_sched_pkg.sv
package sdram_sched_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------
  localparam int ROW_W      = 14;
  localparam int BANK_W     = 3;
  localparam int COL_W      = 9;
  localparam int MASK_W     = 4;
  localparam int ADDR_W     = ROW_W + BANK_W + COL_W;
  localparam int BUS_ADDR_W = 14;
  localparam int GAP_CNT_W  = 4;

  // ----------------------------------------
  // Command spacing, in clock cycles
  // ----------------------------------------
  localparam logic [GAP_CNT_W-1:0] GAP_ACTV = 4'd3;
  localparam logic [GAP_CNT_W-1:0] GAP_PRCH = 4'd3;
  localparam logic [GAP_CNT_W-1:0] GAP_ARSR = 4'd10;
  localparam logic [GAP_CNT_W-1:0] GAP_READ = 4'd2;
  localparam logic [GAP_CNT_W-1:0] GAP_WRTE = 4'd4;

  localparam logic [BUS_ADDR_W-1:0] PRCH_ALL_ADDR = 14'h0400;  // A10 high, all banks

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOP  = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } sdram_cmd_e;

  typedef struct packed {
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
    logic [COL_W-1:0]  col;
  } mem_addr_t;

  typedef struct packed {
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
  } page_t;

  typedef struct packed {
    logic              req;
    logic              we;
    mem_addr_t         addr;
    logic [MASK_W-1:0] mask;
  } port_req_t;

  typedef struct packed {
    logic              valid;
    logic              from_bulk;
    logic              we;
    page_t             page;
    logic [COL_W-1:0]  col;
    logic [MASK_W-1:0] mask;
  } sel_req_t;

  typedef struct packed {
    sdram_cmd_e            cmd;
    logic [BANK_W-1:0]     bank;
    logic [BUS_ADDR_W-1:0] addr;
    logic [MASK_W-1:0]     dm;
  } sdr_bus_t;

endpackage

// File: sdram_sched_top.sv
`timescale 1ns/1ps

module sdram_sched_top (
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  logic                      refresh_strobe,
  input  sdram_sched_pkg::port_req_t rand_port,
  input  sdram_sched_pkg::port_req_t bulk_port,
  output logic                      rand_grant,
  output logic                      bulk_grant,
  output sdram_sched_pkg::sdr_bus_t  sdr
);
  import sdram_sched_pkg::*;

  sel_req_t sel;
  logic     page_hit;
  page_t    open_page;
  logic     page_open;
  logic     refresh_pending;
  logic     cmd_ready;

  request_select u_request_select (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .rand_port (rand_port),
    .bulk_port (bulk_port),
    .open_page (open_page),
    .page_open (page_open),
    .sel       (sel),
    .page_hit  (page_hit)
  );

  bank_tracker u_bank_tracker (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .refresh_strobe  (refresh_strobe),
    .sdr             (sdr),
    .open_page       (open_page),
    .page_open       (page_open),
    .refresh_pending (refresh_pending)
  );

  command_timer u_command_timer (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .sdr       (sdr),
    .cmd_ready (cmd_ready)
  );

  command_issuer u_command_issuer (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .sel             (sel),
    .page_hit        (page_hit),
    .open_page       (open_page),
    .page_open       (page_open),
    .refresh_pending (refresh_pending),
    .cmd_ready       (cmd_ready),
    .sdr             (sdr),
    .rand_grant      (rand_grant),
    .bulk_grant      (bulk_grant)
  );

endmodule

// File: tb.f
sdram_sched_pkg.sv
request_select.sv
bank_tracker.sv
command_timer.sv
command_issuer.sv
sdram_sched_top.sv
tb_clock_gen.sv
tb_sdram_sched.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic INPUT_CLK,
  output logic RST
);

  localparam int HALF_PERIOD  = 20;  // 40 ns clock
  localparam int RESET_CYCLES = 8;

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #(HALF_PERIOD) INPUT_CLK = ~INPUT_CLK;
  end

  initial
  begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    RST = 1'b0;  // Released on a falling edge like every other input
  end

endmodule

// File: tb_sdram_sched.sv
`timescale 1ns/1ps

module tb_sdram_sched;
  import sdram_sched_pkg::*;

  typedef enum logic [1:0] {K_RAND, K_BULK, K_BOTH, K_REFR} entry_kind_e;

  typedef struct packed {
    entry_kind_e kind;
    port_req_t   req;  // Bulk side when both ports request
    port_req_t   alt;  // Random side when both ports request
  } entry_t;

  typedef struct packed {
    sdr_bus_t bus;
    logic     rand_grant;
    logic     bulk_grant;
  } exp_cmd_t;

  localparam int NUM_ENTRIES    = 14;
  localparam int TIMEOUT_CYCLES = 60 * NUM_ENTRIES + 20;

  logic        INPUT_CLK;
  logic        RST;
  logic        refresh_strobe;
  port_req_t   rand_port;
  port_req_t   bulk_port;
  logic        rand_grant;
  logic        bulk_grant;
  sdr_bus_t    sdr;

  entry_t      stim_table [NUM_ENTRIES];
  exp_cmd_t    exp_q [$];
  exp_cmd_t    head;
  logic [31:0] lcg_state;
  logic        model_open;
  page_t       model_page;  // Last activated page
  int          cycle_cnt;
  int          cmds_seen;
  int          last_cycle;
  int          last_gap;
  logic        have_last;

  tb_clock_gen u_clock_gen (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST)
  );

  sdram_sched_top dut (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_port      (rand_port),
    .bulk_port      (bulk_port),
    .rand_grant     (rand_grant),
    .bulk_grant     (bulk_grant),
    .sdr            (sdr)
  );

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
      stop_on_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  function automatic int gap_of(input sdram_cmd_e cmd);
    case (cmd)
      ACTV:    return GAP_ACTV;
      PRCH:    return GAP_PRCH;
      ARSR:    return GAP_ARSR;
      WRTE:    return GAP_WRTE;
      default: return GAP_READ;
    endcase
  endfunction

  function automatic logic [31:0] lcg_step();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Column and mask are free, row and bank are chosen
  function automatic port_req_t make_req(input logic we, input logic [ROW_W-1:0] row,
                                         input logic [BANK_W-1:0] bank);
    logic [31:0] rnd;
    port_req_t   r;
    rnd         = lcg_step();
    r.req       = 1'b1;
    r.we        = we;
    r.addr.row  = row;
    r.addr.bank = bank;
    r.addr.col  = rnd[24:16];
    r.mask      = rnd[31:28];
    return r;
  endfunction

  function automatic entry_t make_entry(input entry_kind_e kind, input port_req_t req,
                                        input port_req_t alt);
    entry_t e;
    e.kind = kind;
    e.req  = req;
    e.alt  = alt;
    return e;
  endfunction

  task automatic build_table();
    port_req_t b;
    port_req_t a;
    stim_table[0]  = make_entry(K_RAND, make_req(1'b0, 14'h0123, 3'd1), '0);  // Empty bank
    stim_table[1]  = make_entry(K_RAND, make_req(1'b1, 14'h0123, 3'd1), '0);  // Hit
    stim_table[2]  = make_entry(K_BULK, make_req(1'b0, 14'h0123, 3'd1), '0);
    stim_table[3]  = make_entry(K_BULK, make_req(1'b1, 14'h2a5c, 3'd1), '0);  // Row miss
    stim_table[4]  = make_entry(K_RAND, make_req(1'b0, 14'h2a5c, 3'd6), '0);  // Bank miss
    stim_table[5]  = make_entry(K_REFR, '0, '0);
    stim_table[6]  = make_entry(K_RAND, make_req(1'b1, 14'h0001, 3'd0), '0);
    b = make_req(1'b0, 14'h0001, 3'd0);
    a = make_req(1'b1, 14'h3fff, 3'd7);
    stim_table[7]  = make_entry(K_BOTH, b, a);
    b = make_req(1'b1, 14'h1000, 3'd3);
    a = make_req(1'b0, 14'h3fff, 3'd7);  // Would hit, but bulk goes first
    stim_table[8]  = make_entry(K_BOTH, b, a);
    stim_table[9]  = make_entry(K_REFR, '0, '0);
    stim_table[10] = make_entry(K_REFR, '0, '0);  // No page open
    stim_table[11] = make_entry(K_BULK, make_req(1'b0, 14'h0aaa, 3'd2), '0);
    b = make_req(1'b1, 14'h0aaa, 3'd2);
    a = make_req(1'b0, 14'h0aaa, 3'd2);
    stim_table[12] = make_entry(K_BOTH, b, a);
    stim_table[13] = make_entry(K_RAND, make_req(1'b1, 14'h0aaa, 3'd5), '0);
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  task automatic push_cmd(input sdram_cmd_e cmd, input logic [BANK_W-1:0] bank,
                          input logic [BUS_ADDR_W-1:0] addr, input logic [MASK_W-1:0] dm,
                          input logic rg, input logic bg);
    exp_cmd_t e;
    e.bus.cmd    = cmd;
    e.bus.bank   = bank;
    e.bus.addr   = addr;
    e.bus.dm     = dm;
    e.rand_grant = rg;
    e.bulk_grant = bg;
    exp_q.push_back(e);
  endtask

  task automatic expect_access(input port_req_t r, input logic from_bulk);
    page_t                 want;
    logic [BUS_ADDR_W-1:0] col_addr;
    sdram_cmd_e            rw_cmd;
    want.row  = r.addr.row;
    want.bank = r.addr.bank;
    col_addr  = '0;
    col_addr[COL_W:1] = r.addr.col;  // Word column, A0 low
    if (r.we)
      rw_cmd = WRTE;
    else
      rw_cmd = READ;
    if (!(model_open && model_page == want))
    begin
      if (model_open)
        push_cmd(PRCH, model_page.bank, PRCH_ALL_ADDR, '0, 1'b0, 1'b0);
      push_cmd(ACTV, want.bank, want.row, '0, 1'b0, 1'b0);
      model_open = 1'b1;
      model_page = want;
    end
    push_cmd(rw_cmd, want.bank, col_addr, r.mask, !from_bulk, from_bulk);
  endtask

  task automatic expect_refresh();
    if (model_open)
      push_cmd(PRCH, model_page.bank, PRCH_ALL_ADDR, '0, 1'b0, 1'b0);
    push_cmd(ARSR, model_page.bank, PRCH_ALL_ADDR, '0, 1'b0, 1'b0);
    model_open = 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic apply_entry(input entry_t e);
    int target;
    case (e.kind)
      K_RAND:
      begin
        expect_access(e.req, 1'b0);
        rand_port = e.req;
      end
      K_BULK:
      begin
        expect_access(e.req, 1'b1);
        bulk_port = e.req;
      end
      K_BOTH:
      begin
        expect_access(e.req, 1'b1);  // Bulk served first
        expect_access(e.alt, 1'b0);
        bulk_port = e.req;
        rand_port = e.alt;
      end
      default:
      begin
        expect_refresh();
        refresh_strobe = ~refresh_strobe;
      end
    endcase
    target = cmds_seen + exp_q.size();
    do
    begin
      @(negedge INPUT_CLK);
      if (rand_grant)
        rand_port.req = 1'b0;  // Requester lets go after grant
      if (bulk_grant)
        bulk_port.req = 1'b0;
    end
    while (cmds_seen != target || rand_port.req || bulk_port.req);
  endtask

  initial
  begin
    lcg_state      = 32'h379e_230e;
    refresh_strobe = 1'b0;
    rand_port      = '0;
    bulk_port      = '0;
    model_open     = 1'b0;
    model_page     = '0;
    cycle_cnt      = 0;
    cmds_seen      = 0;
    last_cycle     = 0;
    last_gap       = 0;
    have_last      = 1'b0;
    build_table();
    wait (RST == 1'b0);
    repeat (4) @(negedge INPUT_CLK);  // Idle bus check before stimulus
    for (int i = 0; i < NUM_ENTRIES; i++)
      apply_entry(stim_table[i]);
    repeat (20) @(negedge INPUT_CLK);  // Bus stays quiet after the last entry
    $display("TEST PASS");
    $finish;
  end

  // ----------------------------------------
  // Bus monitor
  // ----------------------------------------
  initial
  begin
    @(posedge INPUT_CLK);
    forever
    begin
      @(negedge INPUT_CLK);
      if (sdr.cmd !== NOP)
      begin
        if (exp_q.size() == 0)
          stop_on_failure("A command appeared on the bus when none was expected");
        head = exp_q.pop_front();
        compare_value("sdr.cmd", sdr.cmd, head.bus.cmd);
        compare_value("sdr.bank", sdr.bank, head.bus.bank);
        compare_value("sdr.addr", sdr.addr, head.bus.addr);
        compare_value("sdr.dm", sdr.dm, head.bus.dm);
        compare_value("rand_grant", rand_grant, head.rand_grant);
        compare_value("bulk_grant", bulk_grant, head.bulk_grant);
        if (have_last && (cycle_cnt - last_cycle) < last_gap)
          stop_on_failure($sformatf("Two commands only %0d cycles apart, the minimum is %0d",
                                    cycle_cnt - last_cycle, last_gap));
        have_last  = 1'b1;
        last_cycle = cycle_cnt;
        last_gap   = gap_of(head.bus.cmd);
        cmds_seen <= cmds_seen + 1;
      end
      else
      begin
        compare_value("rand_grant", rand_grant, 1'b0);
        compare_value("bulk_grant", bulk_grant, 1'b0);
      end
    end
  end

  always @(posedge INPUT_CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_on_failure("Timeout, the test did not finish within its cycle limit");
  end

endmodule
